//--- source/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Byte address width on every port
`define MEM_ADDR_W 32

// Array sizes in 32-bit words
`define DMEM_DEPTH 1024 // 4 KiB main memory
`define BMEM_DEPTH 256  // 1 KiB boot memory

// Boot region at 0x1000_0000, decoded on the top nibble of the fetch address
`define BMEM_SEL_ADDR_HIGH 31
`define BMEM_SEL_ADDR_LOW  28
`define BMEM_ADDR_MATCH    4'h1

`endif

//--- source/mem_pkg.sv
package mem_pkg;

`include "mem_config.svh"

    // Byte address as seen by every requester
    typedef logic [`MEM_ADDR_W-1:0] addr_t;

    typedef logic [31:0] word_t;    // Fixed data word
    typedef logic [3:0]  byte_sel_t; // One enable per byte lane

    // Holder of the main memory data port for the access in flight
    typedef enum logic [1:0] {
        OWNER_NONE = 2'b00,
        OWNER_LSU  = 2'b01,
        OWNER_MMU  = 2'b10
    } dmem_owner_e;

    // Memory serving the fetch in flight
    typedef enum logic [1:0] {
        FETCH_NONE = 2'b00,
        FETCH_DMEM = 2'b01,
        FETCH_BMEM = 2'b10
    } fetch_src_e;

endpackage : mem_pkg

//--- source/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if
    import mem_pkg::*;
();

    addr_t     addr;     // Byte address
    word_t     w_data;
    byte_sel_t sel_byte; // Write lane enables
    logic      w_en;
    logic      stb;      // One access per high cycle
    word_t     r_data;   // Valid with ack
    logic      ack;

    modport requester (
        output addr, w_data, sel_byte, w_en, stb,
        input  r_data, ack
    );

    modport memory (
        input  addr, w_data, sel_byte, w_en, stb,
        output r_data, ack
    );

endinterface : mem_bus_if

//--- source/dualport_mem.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module dualport_mem
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,

    // Data port, shared by load/store and MMU through the router
    mem_bus_if.memory dbus,

    // Fetch port, read only
    input  addr_t     if_addr_i,
    input  logic      if_req_i,
    output word_t     if_r_data_o,
    output logic      if_ack_o
);

    localparam int unsigned DEPTH = `DMEM_DEPTH;
    localparam int unsigned IDX_W = $clog2(DEPTH);

    word_t            mem [DEPTH];
    logic [IDX_W-1:0] d_idx;
    logic [IDX_W-1:0] i_idx;

    // Word index from the byte address
    assign d_idx = dbus.addr[IDX_W+1:2];
    assign i_idx = if_addr_i[IDX_W+1:2];

    // Both ports read before the write lands, so a collision sees the old word
    always_ff @(posedge clk) begin
        if (dbus.stb) begin
            dbus.r_data <= mem[d_idx];
            if (dbus.w_en) begin
                for (int b = 0; b < 4; b++) begin
                    if (dbus.sel_byte[b]) begin
                        mem[d_idx][b*8 +: 8] <= dbus.w_data[b*8 +: 8];
                    end
                end
            end
        end
        if (if_req_i) begin
            if_r_data_o <= mem[i_idx]; // Fetch word
        end
    end

    // One-cycle acks
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dbus.ack <= 1'b0;
            if_ack_o <= 1'b0;
        end else begin
            dbus.ack <= dbus.stb;
            if_ack_o <= if_req_i;
        end
    end

endmodule : dualport_mem

//--- source/boot_mem.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module boot_mem
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,

    // Load/store bus, straight from the top level
    input  addr_t     dbus_addr_i,
    input  word_t     dbus_w_data_i,
    input  byte_sel_t dbus_sel_byte_i,
    input  logic      dbus_w_en_i,
    input  logic      dbus_stb_i,
    input  logic      bmem_sel_i,
    output word_t     bmem_r_data_o,
    output logic      bmem_ack_o,

    // Fetch port, request already gated by the boot decode
    input  addr_t     if_addr_i,
    input  logic      if_req_i,
    output word_t     if_r_data_o,
    output logic      if_ack_o
);

    localparam int unsigned DEPTH = `BMEM_DEPTH;
    localparam int unsigned IDX_W = $clog2(DEPTH);

    word_t            mem [DEPTH];
    logic             d_access;
    logic [IDX_W-1:0] d_idx;
    logic [IDX_W-1:0] i_idx;

    assign d_access = dbus_stb_i & bmem_sel_i; // Decoder select qualifies the strobe
    assign d_idx    = dbus_addr_i[IDX_W+1:2];  // Low bits only, region bits ignored
    assign i_idx    = if_addr_i[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (d_access) begin
            bmem_r_data_o <= mem[d_idx];
            if (dbus_w_en_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (dbus_sel_byte_i[b]) begin
                        mem[d_idx][b*8 +: 8] <= dbus_w_data_i[b*8 +: 8];
                    end
                end
            end
        end
        if (if_req_i) begin
            if_r_data_o <= mem[i_idx];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bmem_ack_o <= 1'b0;
            if_ack_o   <= 1'b0;
        end else begin
            bmem_ack_o <= d_access;
            if_ack_o   <= if_req_i;
        end
    end

endmodule : boot_mem

//--- source/mem_port_router.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_port_router
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,

    input  addr_t     dbus_addr_i,
    input  word_t     dbus_w_data_i,
    input  byte_sel_t dbus_sel_byte_i,
    input  logic      dbus_w_en_i,
    input  logic      dbus_stb_i,
    input  logic      dmem_sel_i,

    input  addr_t     mmu_paddr_i,
    input  logic      mmu_r_req_i,
    output word_t     mmu_r_data_o,
    output logic      mmu_r_valid_o,

    mem_bus_if.requester dmem,

    output word_t     dmem_r_data_o,
    output logic      dmem_ack_o,

    input  logic      if_req_i,
    input  addr_t     if_addr_i,
    output logic      dmem_if_req_o,
    output logic      bmem_if_req_o,
    input  word_t     dmem_if_r_data_i,
    input  logic      dmem_if_ack_i,
    input  word_t     bmem_if_r_data_i,
    input  logic      bmem_if_ack_i,
    output word_t     if_r_data_o,
    output logic      if_ack_o
);

    dmem_owner_e owner_q;
    fetch_src_e  fetch_src_q;
    logic        bmem_match;
    logic        lsu_grant;
    logic        mmu_grant;

    assign bmem_match = (if_addr_i[`BMEM_SEL_ADDR_HIGH:`BMEM_SEL_ADDR_LOW] == `BMEM_ADDR_MATCH);
    assign bmem_if_req_o = if_req_i & bmem_match;
    assign dmem_if_req_o = if_req_i & ~bmem_match;

    // MMU holds its request until valid, so skip the edge where its read is still in flight
    assign lsu_grant = dmem_sel_i & dbus_stb_i;
    assign mmu_grant = mmu_r_req_i & ~dmem_sel_i & (owner_q != OWNER_MMU);

    always_comb begin
        dmem.addr     = '0;
        dmem.w_data   = '0;
        dmem.sel_byte = '0;
        dmem.w_en     = 1'b0;
        dmem.stb      = 1'b0;
        if (dmem_sel_i) begin // Load/store always wins
            dmem.addr     = dbus_addr_i;
            dmem.w_data   = dbus_w_data_i;
            dmem.sel_byte = dbus_sel_byte_i;
            dmem.w_en     = dbus_w_en_i;
            dmem.stb      = dbus_stb_i;
        end else if (mmu_grant) begin
            dmem.addr = mmu_paddr_i; // Plain read, no lanes
            dmem.stb  = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            owner_q     <= OWNER_NONE;
            fetch_src_q <= FETCH_NONE;
        end else begin
            if (lsu_grant)      owner_q <= OWNER_LSU;
            else if (mmu_grant) owner_q <= OWNER_MMU;
            else                owner_q <= OWNER_NONE;

            if (!if_req_i)       fetch_src_q <= FETCH_NONE;
            else if (bmem_match) fetch_src_q <= FETCH_BMEM;
            else                 fetch_src_q <= FETCH_DMEM;
        end
    end

    // Responses follow the recorded owner, never the live selects
    assign dmem_ack_o    = dmem.ack & (owner_q == OWNER_LSU);
    assign dmem_r_data_o = (owner_q == OWNER_LSU) ? dmem.r_data : '0;
    assign mmu_r_valid_o = dmem.ack & (owner_q == OWNER_MMU);
    assign mmu_r_data_o  = (owner_q == OWNER_MMU) ? dmem.r_data : '0;

    always_comb begin
        case (fetch_src_q)
            FETCH_DMEM: begin
                if_r_data_o = dmem_if_r_data_i;
                if_ack_o    = dmem_if_ack_i;
            end
            FETCH_BMEM: begin
                if_r_data_o = bmem_if_r_data_i;
                if_ack_o    = bmem_if_ack_i;
            end
            default: begin
                if_r_data_o = '0;
                if_ack_o    = 1'b0;
            end
        endcase
    end

endmodule : mem_port_router

//--- source/mem_top.sv
`timescale 1ns/1ps

module mem_top
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,

    input  addr_t     dbus_addr_i,
    input  word_t     dbus_w_data_i,
    input  byte_sel_t dbus_sel_byte_i,
    input  logic      dbus_w_en_i,
    input  logic      dbus_stb_i,

    input  logic      dmem_sel_i,  // From the bus address decoder
    input  logic      bmem_sel_i,

    output word_t     dmem_r_data_o,
    output logic      dmem_ack_o,
    output word_t     bmem_r_data_o,
    output logic      bmem_ack_o,

    input  addr_t     if_addr_i,
    input  logic      if_req_i,
    output word_t     if_r_data_o,
    output logic      if_ack_o,

    input  addr_t     mmu_paddr_i,
    input  logic      mmu_r_req_i,
    output word_t     mmu_r_data_o,
    output logic      mmu_r_valid_o
);

    mem_bus_if dmem_bus ();

    logic  dmem_if_req;
    logic  bmem_if_req;
    word_t dmem_if_r_data;
    logic  dmem_if_ack;
    word_t bmem_if_r_data;
    logic  bmem_if_ack;

    mem_port_router u_mem_port_router (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .dbus_addr_i      (dbus_addr_i),
        .dbus_w_data_i    (dbus_w_data_i),
        .dbus_sel_byte_i  (dbus_sel_byte_i),
        .dbus_w_en_i      (dbus_w_en_i),
        .dbus_stb_i       (dbus_stb_i),
        .dmem_sel_i       (dmem_sel_i),
        .mmu_paddr_i      (mmu_paddr_i),
        .mmu_r_req_i      (mmu_r_req_i),
        .mmu_r_data_o     (mmu_r_data_o),
        .mmu_r_valid_o    (mmu_r_valid_o),
        .dmem             (dmem_bus.requester),
        .dmem_r_data_o    (dmem_r_data_o),
        .dmem_ack_o       (dmem_ack_o),
        .if_req_i         (if_req_i),
        .if_addr_i        (if_addr_i),
        .dmem_if_req_o    (dmem_if_req),
        .bmem_if_req_o    (bmem_if_req),
        .dmem_if_r_data_i (dmem_if_r_data),
        .dmem_if_ack_i    (dmem_if_ack),
        .bmem_if_r_data_i (bmem_if_r_data),
        .bmem_if_ack_i    (bmem_if_ack),
        .if_r_data_o      (if_r_data_o),
        .if_ack_o         (if_ack_o)
    );

    dualport_mem u_dualport_mem (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .dbus        (dmem_bus.memory),
        .if_addr_i   (if_addr_i),
        .if_req_i    (dmem_if_req),
        .if_r_data_o (dmem_if_r_data),
        .if_ack_o    (dmem_if_ack)
    );

    // Boot memory sees the load/store bus directly
    boot_mem u_boot_mem (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .dbus_addr_i     (dbus_addr_i),
        .dbus_w_data_i   (dbus_w_data_i),
        .dbus_sel_byte_i (dbus_sel_byte_i),
        .dbus_w_en_i     (dbus_w_en_i),
        .dbus_stb_i      (dbus_stb_i),
        .bmem_sel_i      (bmem_sel_i),
        .bmem_r_data_o   (bmem_r_data_o),
        .bmem_ack_o      (bmem_ack_o),
        .if_addr_i       (if_addr_i),
        .if_req_i        (bmem_if_req),
        .if_r_data_o     (bmem_if_r_data),
        .if_ack_o        (bmem_if_ack)
    );

endmodule : mem_top

//--- test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(PERIOD_NS / 2.0) clk_o = ~clk_o; // Free running, 50% duty

endmodule : tb_clk_gen

//--- test/mem_top_properties.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_top_properties
    import mem_pkg::*;
(
    input logic      clk, rst_n_i,
    input addr_t     dbus_addr_i, if_addr_i, mmu_paddr_i,
    input word_t     dbus_w_data_i,
    input byte_sel_t dbus_sel_byte_i,
    input logic      dbus_w_en_i, dbus_stb_i, dmem_sel_i, bmem_sel_i,
    input word_t     dmem_r_data_o, bmem_r_data_o, if_r_data_o, mmu_r_data_o,
    input logic      dmem_ack_o, bmem_ack_o, if_ack_o, mmu_r_valid_o,
    input logic      if_req_i, mmu_r_req_i
);

    localparam int unsigned DIDX_W = $clog2(`DMEM_DEPTH);
    localparam int unsigned BIDX_W = $clog2(`BMEM_DEPTH);

    int unsigned err_cnt = 0; // Failed checks so far

    // Shadow copies built from the writes seen on the bus
    word_t dmem_shadow [`DMEM_DEPTH];
    word_t bmem_shadow [`BMEM_DEPTH];
    word_t exp_dmem, exp_bmem, exp_if, exp_mmu;
    logic  dmem_acc, bmem_acc, mmu_acc, if_boot;
    logic  mmu_busy; // Walker read taken on the last edge

    assign dmem_acc = dbus_stb_i & dmem_sel_i;
    assign bmem_acc = dbus_stb_i & bmem_sel_i;
    assign mmu_acc  = mmu_r_req_i & ~dmem_sel_i & ~mmu_busy; // Held request is taken once
    assign if_boot  = if_addr_i[`BMEM_SEL_ADDR_HIGH:`BMEM_SEL_ADDR_LOW] == `BMEM_ADDR_MATCH;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mmu_busy <= 1'b0;
        end else begin
            mmu_busy <= mmu_acc;
        end
    end

    // Expected words are captured before this edge's write lands
    always_ff @(posedge clk) begin
        exp_dmem <= dmem_shadow[dbus_addr_i[DIDX_W+1:2]];
        exp_bmem <= bmem_shadow[dbus_addr_i[BIDX_W+1:2]];
        exp_mmu  <= dmem_shadow[mmu_paddr_i[DIDX_W+1:2]];
        exp_if   <= if_boot ? bmem_shadow[if_addr_i[BIDX_W+1:2]]
                            : dmem_shadow[if_addr_i[DIDX_W+1:2]];
        for (int b = 0; b < 4; b++) begin
            if (dbus_w_en_i && dbus_sel_byte_i[b]) begin
                if (dmem_acc) begin
                    dmem_shadow[dbus_addr_i[DIDX_W+1:2]][b*8 +: 8] <= dbus_w_data_i[b*8 +: 8];
                end
                if (bmem_acc) begin
                    bmem_shadow[dbus_addr_i[BIDX_W+1:2]][b*8 +: 8] <= dbus_w_data_i[b*8 +: 8];
                end
            end
        end
    end

    a_dmem_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_ack_o == $past(dmem_acc) && (!dmem_ack_o || dmem_r_data_o === exp_dmem))
        else begin
            err_cnt++;
            $error("ERROR dmem_ack_o %h dmem_r_data_o %h, expected data %h",
                   $sampled(dmem_ack_o), $sampled(dmem_r_data_o), $sampled(exp_dmem));
        end

    a_bmem_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
        bmem_ack_o == $past(bmem_acc) && (!bmem_ack_o || bmem_r_data_o === exp_bmem))
        else begin
            err_cnt++;
            $error("ERROR bmem_ack_o %h bmem_r_data_o %h, expected data %h",
                   $sampled(bmem_ack_o), $sampled(bmem_r_data_o), $sampled(exp_bmem));
        end

    a_if_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
        if_ack_o == $past(if_req_i) && (!if_ack_o || if_r_data_o === exp_if))
        else begin
            err_cnt++;
            $error("ERROR if_ack_o %h if_r_data_o %h, expected data %h",
                   $sampled(if_ack_o), $sampled(if_r_data_o), $sampled(exp_if));
        end

    // Load/store acks during a wait must never show up as walker data
    a_mmu_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        mmu_r_valid_o == $past(mmu_acc) && (!mmu_r_valid_o || mmu_r_data_o === exp_mmu))
        else begin
            err_cnt++;
            $error("ERROR mmu_r_valid_o %h mmu_r_data_o %h, expected data %h",
                   $sampled(mmu_r_valid_o), $sampled(mmu_r_data_o), $sampled(exp_mmu));
        end

endmodule : mem_top_properties

//--- test/mem_top_tb.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_top_tb
    import mem_pkg::*;
();

    localparam word_t       PATTERN   = 32'h5A5A_A5A5;
    localparam addr_t       BOOT_BASE = addr_t'(`BMEM_ADDR_MATCH) << `BMEM_SEL_ADDR_LOW;
    localparam int unsigned DIDX_W    = $clog2(`DMEM_DEPTH);
    localparam int unsigned BIDX_W    = $clog2(`BMEM_DEPTH);
    localparam int unsigned MMU_WAIT  = 32; // Cycles before a walker read counts as lost

    logic      clk, rst_n_i;
    addr_t     dbus_addr_i, if_addr_i, mmu_paddr_i;
    word_t     dbus_w_data_i, dmem_r_data_o, bmem_r_data_o, if_r_data_o, mmu_r_data_o;
    byte_sel_t dbus_sel_byte_i;
    logic      dbus_w_en_i, dbus_stb_i, dmem_sel_i, bmem_sel_i, if_req_i, mmu_r_req_i;
    logic      dmem_ack_o, bmem_ack_o, if_ack_o, mmu_r_valid_o;

    logic [31:0] lfsr     = 32'haf94_de94;
    int unsigned timeouts = 0;

    tb_clk_gen u_tb_clk_gen (.clk_o(clk));

    mem_top u_mem_top (.*);

    bind mem_top mem_top_properties u_mem_top_properties (.*);

    // Galois LFSR, one step per bit handed out
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return v;
    endfunction

    function automatic addr_t pick_addr(input logic boot);
        if (boot) begin
            return BOOT_BASE | (rand_bits(BIDX_W) << 2);
        end
        return rand_bits(DIDX_W) << 2;
    endfunction

    task automatic drive_dbus(input addr_t addr, input word_t data, input byte_sel_t sel,
                              input logic we, input logic boot);
        dbus_addr_i     <= addr;
        dbus_w_data_i   <= data;
        dbus_sel_byte_i <= sel;
        dbus_w_en_i     <= we;
        dbus_stb_i      <= 1'b1;
        dmem_sel_i      <= ~boot;
        bmem_sel_i      <= boot;
    endtask

    task automatic go_idle();
        dbus_stb_i <= 1'b0;
        dmem_sel_i <= 1'b0;
        bmem_sel_i <= 1'b0;
        if_req_i   <= 1'b0;
    endtask

    // One load/store access with a fetch alongside it
    task automatic mixed_cycle(input logic lane_write);
        logic      lsu_boot, fetch_boot, fetch;
        addr_t     lsu_addr, fetch_addr;
        byte_sel_t sel;
        lsu_boot   = rand_bits(1) != 0;
        lsu_addr   = pick_addr(lsu_boot);
        sel        = byte_sel_t'(rand_bits(4));
        fetch      = rand_bits(1) != 0;
        fetch_boot = rand_bits(1) != 0;
        fetch_addr = pick_addr(fetch_boot);
        @(posedge clk);
        drive_dbus(lsu_addr, 32'hFFFF_FFFF, sel, lane_write, lsu_boot);
        if_req_i  <= fetch;
        if_addr_i <= fetch_addr;
    endtask

    // Walker read that waits behind a few cycles of loads
    task automatic mmu_read();
        addr_t       paddr;
        int unsigned hold;
        int unsigned waited;
        paddr  = pick_addr(1'b0);
        hold   = rand_bits(2);
        waited = 0;
        @(posedge clk);
        mmu_paddr_i <= paddr;
        mmu_r_req_i <= 1'b1;
        for (int i = 0; i < hold; i++) begin
            drive_dbus(pick_addr(1'b0), '0, '0, 1'b0, 1'b0);
            @(posedge clk);
        end
        go_idle();
        do begin
            @(negedge clk);
            waited++;
        end while (!mmu_r_valid_o && waited < MMU_WAIT);
        if (!mmu_r_valid_o) begin
            timeouts++;
            $display("Timed out waiting for the MMU read of address %h", paddr);
        end
        @(posedge clk);
        mmu_r_req_i <= 1'b0;
    endtask

    initial begin
        rst_n_i         <= 1'b0;
        dbus_addr_i     <= '0;
        dbus_w_data_i   <= '0;
        dbus_sel_byte_i <= '0;
        dbus_w_en_i     <= 1'b0;
        if_addr_i       <= '0;
        mmu_paddr_i     <= '0;
        mmu_r_req_i     <= 1'b0;
        go_idle();
        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;
        repeat (4) @(posedge clk); // Idle, no ack may rise

        for (int i = 0; i < `DMEM_DEPTH; i++) begin
            @(posedge clk);
            drive_dbus(i * 4, (i * 4) ^ PATTERN, 4'hF, 1'b1, 1'b0);
        end
        for (int i = 0; i < `BMEM_DEPTH; i++) begin
            @(posedge clk);
            drive_dbus(BOOT_BASE | (i * 4), (BOOT_BASE | (i * 4)) ^ PATTERN, 4'hF, 1'b1, 1'b1);
        end
        repeat (300) mixed_cycle(1'b1); // Lane writes of 0xFF
        repeat (600) mixed_cycle(1'b0);
        @(posedge clk);
        go_idle();
        repeat (24) mmu_read();
        repeat (4) @(posedge clk);

        $display("assertion errors: %0d, timeouts: %0d",
                 u_mem_top.u_mem_top_properties.err_cnt, timeouts);
        if (u_mem_top.u_mem_top_properties.err_cnt == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : mem_top_tb

//--- files.f
+incdir+source
source/mem_pkg.sv
source/mem_bus_if.sv
source/dualport_mem.sv
source/boot_mem.sv
source/mem_port_router.sv
source/mem_top.sv
test/tb_clk_gen.sv
test/mem_top_properties.sv
test/mem_top_tb.sv

//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - include_dirs:
      - source
    files:
      - source/mem_pkg.sv
      - source/mem_bus_if.sv
      - source/dualport_mem.sv
      - source/boot_mem.sv
      - source/mem_port_router.sv
      - source/mem_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/tb_clk_gen.sv
      - test/mem_top_properties.sv
      - test/mem_top_tb.sv
